//--- src/core_pkg.sv
`default_nettype none

package core_pkg;

	localparam int NUM_REGS = 16;
	localparam int ADDR_W = 30;  // Word address
	localparam int LDM_STEP = 4;

	// Instruction fields
	localparam int CLASS_HI = 31;
	localparam int CLASS_LO = 30;
	localparam int OP_HI = 29;
	localparam int OP_LO = 27;
	localparam int IMM_FLAG = 26;
	localparam int LOAD_BIT = 29;
	localparam int PRE_BIT = 28;
	localparam int INC_BIT = 27;
	localparam int WB_BIT = 25;
	localparam int RD_HI = 23;
	localparam int RD_LO = 20;
	localparam int RN_HI = 19;
	localparam int RN_LO = 16;
	localparam int RM_HI = 3;
	localparam int RM_LO = 0;
	localparam int IMM_HI = 11;  // Also the ldst byte offset
	localparam int IMM_LO = 0;
	localparam int LIST_HI = 15;
	localparam int LIST_LO = 0;

	typedef logic [31:0] word;
	typedef logic [3:0] reg_num;
	typedef logic [15:0] reg_list;

	typedef enum logic [2:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_ORR,
		OP_MOV
	} alu_op;

	typedef enum logic [1:0] {
		CLASS_DATA = 2'b00,
		CLASS_LDST = 2'b01,
		CLASS_LDM  = 2'b10
	} insn_class;

	typedef enum logic [1:0] {
		ISSUE,
		TRANSFER,
		BASE_WRITEBACK
	} ctrl_cycle;

	typedef struct packed {
		alu_op       op;
		logic        is_imm;
		reg_num      rd;
		reg_num      rn;
		reg_num      rm;
		logic [11:0] imm;
	} data_decode;

	typedef struct packed {
		logic        enable;
		logic        multiple;
		logic        load;
		logic        pre;
		logic        increment;
		logic        writeback;
		reg_num      rd;
		reg_num      rn;
		logic [11:0] offset;
		reg_list     regs;
	} ldst_decode;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic              write;
		word               wdata;
	} mem_request;

endpackage

`default_nettype wire

//--- src/core_ldst_pop.sv
`default_nettype none
`timescale 1ns/1ps

module core_ldst_pop (
	input  core_pkg::reg_list regs,
	output logic              valid,
	output core_pkg::reg_num  pop_lower,
	output core_pkg::reg_num  pop_upper,
	output core_pkg::reg_list next_lower,
	output core_pkg::reg_list next_upper
);

	assign valid = |regs;

	always_comb begin
		pop_lower = '0;
		pop_upper = '0;
		// Last hit wins on each scan
		for (int i = core_pkg::NUM_REGS - 1; i >= 0; i--) begin
			if (regs[i])
				pop_lower = core_pkg::reg_num'(i);
		end
		for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
			if (regs[i])
				pop_upper = core_pkg::reg_num'(i);
		end
	end

	assign next_lower = regs & ~(core_pkg::reg_list'(1) << pop_lower);
	assign next_upper = regs & ~(core_pkg::reg_list'(1) << pop_upper);

endmodule

`default_nettype wire

//--- src/core_decode.sv
`default_nettype none
`timescale 1ns/1ps

module core_decode (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 insn_req,
	input  core_pkg::word        insn,
	input  logic                 ready,
	output logic                 insn_ack,
	output logic                 issue,
	output core_pkg::data_decode dec_data,
	output core_pkg::ldst_decode dec_ldst
);

	core_pkg::word insn_q;
	core_pkg::insn_class cls;
	logic accept;

	assign accept = insn_req && ready && !insn_ack;
	assign cls = core_pkg::insn_class'(insn_q[core_pkg::CLASS_HI:core_pkg::CLASS_LO]);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			insn_ack <= 1'b0;
			issue <= 1'b0;
		end else begin
			issue <= accept;  // One cycle, as ack rises
			if (accept)
				insn_ack <= 1'b1;
			else if (insn_ack && !insn_req)
				insn_ack <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			insn_q <= insn;
	end

	always_comb begin
		dec_data.op = core_pkg::alu_op'(insn_q[core_pkg::OP_HI:core_pkg::OP_LO]);
		dec_data.is_imm = insn_q[core_pkg::IMM_FLAG];
		dec_data.rd = insn_q[core_pkg::RD_HI:core_pkg::RD_LO];
		dec_data.rn = insn_q[core_pkg::RN_HI:core_pkg::RN_LO];
		dec_data.rm = insn_q[core_pkg::RM_HI:core_pkg::RM_LO];
		dec_data.imm = insn_q[core_pkg::IMM_HI:core_pkg::IMM_LO];

		// Unknown class falls back to a data op
		dec_ldst.enable = cls == core_pkg::CLASS_LDST || cls == core_pkg::CLASS_LDM;
		dec_ldst.multiple = cls == core_pkg::CLASS_LDM;
		dec_ldst.load = insn_q[core_pkg::LOAD_BIT];
		dec_ldst.pre = insn_q[core_pkg::PRE_BIT];
		dec_ldst.increment = insn_q[core_pkg::INC_BIT];
		dec_ldst.writeback = insn_q[core_pkg::WB_BIT];
		dec_ldst.rd = insn_q[core_pkg::RD_HI:core_pkg::RD_LO];
		dec_ldst.rn = insn_q[core_pkg::RN_HI:core_pkg::RN_LO];
		dec_ldst.offset = insn_q[core_pkg::IMM_HI:core_pkg::IMM_LO];
		dec_ldst.regs = insn_q[core_pkg::LIST_HI:core_pkg::LIST_LO];
	end

endmodule

`default_nettype wire

//--- src/core_control.sv
`default_nettype none
`timescale 1ns/1ps

module core_control (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 issue,
	input  core_pkg::data_decode dec_data,
	input  core_pkg::ldst_decode dec_ldst,
	input  core_pkg::word        rd_value_a,
	input  core_pkg::word        rd_value_b,
	input  core_pkg::word        q_alu,
	input  logic                 mem_done,
	input  core_pkg::word        mem_rdata,
	output logic                 ready,
	output core_pkg::reg_num     ra,
	output core_pkg::reg_num     rb,
	output core_pkg::alu_op      alu,
	output core_pkg::word        alu_a,
	output core_pkg::word        alu_b,
	output logic                 mem_start,
	output core_pkg::mem_request mem,
	output logic                 wb_en,
	output core_pkg::reg_num     wb_rd,
	output core_pkg::word        wb_value
);

	core_pkg::ctrl_cycle cycle;
	core_pkg::data_decode data_q;
	core_pkg::ldst_decode ldst_q;
	core_pkg::reg_list mem_regs;
	core_pkg::reg_list next_lower;
	core_pkg::reg_list next_upper;
	core_pkg::reg_num pop_lower;
	core_pkg::reg_num pop_upper;
	core_pkg::reg_num popped;
	core_pkg::reg_num final_rd;
	core_pkg::word saved_base;
	core_pkg::word base;
	logic pop_valid;
	logic started;
	logic final_writeback;
	logic launch;

	core_ldst_pop ldst_pop (
		.regs(mem_regs),
		.valid(pop_valid),
		.pop_lower(pop_lower),
		.pop_upper(pop_upper),
		.next_lower(next_lower),
		.next_upper(next_upper)
	);

	assign popped = ldst_q.increment ? pop_lower : pop_upper;
	assign base = started ? saved_base : rd_value_a;  // Base is read once, then tracked
	assign launch = cycle == core_pkg::TRANSFER && (!started || mem_done) && pop_valid;
	assign ready = cycle == core_pkg::ISSUE && !issue;
	assign ra = ldst_q.rn;  // Rn shares its field across classes
	assign rb = cycle == core_pkg::ISSUE ? data_q.rm : popped;  // Store data

	always_comb begin
		if (cycle == core_pkg::ISSUE) begin
			alu = data_q.op;
			alu_a = rd_value_a;
			alu_b = data_q.is_imm ? core_pkg::word'(data_q.imm) : rd_value_b;
		end else begin
			// Address step in the transfer direction
			alu = ldst_q.increment ? core_pkg::OP_ADD : core_pkg::OP_SUB;
			alu_a = base;
			alu_b = ldst_q.multiple ? core_pkg::word'(core_pkg::LDM_STEP)
				: core_pkg::word'(ldst_q.offset);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cycle <= core_pkg::ISSUE;
			started <= 1'b0;
			final_writeback <= 1'b0;
			mem_start <= 1'b0;
			wb_en <= 1'b0;
		end else begin
			mem_start <= 1'b0;
			wb_en <= 1'b0;
			unique case (cycle)
				core_pkg::ISSUE: begin
					wb_en <= final_writeback;  // Second stage of a data op
					final_writeback <= 1'b0;
					if (issue) begin
						final_writeback <= !dec_ldst.enable;
						if (dec_ldst.enable)
							cycle <= core_pkg::TRANSFER;
					end
				end
				core_pkg::TRANSFER: begin
					if (mem_done)
						wb_en <= ldst_q.load;
					if (launch) begin
						mem_start <= 1'b1;
						started <= 1'b1;
					end else if (!started || mem_done) begin
						// List exhausted
						started <= 1'b0;
						cycle <= ldst_q.writeback ? core_pkg::BASE_WRITEBACK : core_pkg::ISSUE;
					end
				end
				core_pkg::BASE_WRITEBACK: begin
					wb_en <= 1'b1;
					cycle <= core_pkg::ISSUE;
				end
				default: cycle <= core_pkg::ISSUE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (cycle == core_pkg::ISSUE && issue) begin
			data_q <= dec_data;
			ldst_q <= dec_ldst;
			// A single transfer is a list of one
			mem_regs <= dec_ldst.multiple ? dec_ldst.regs
				: core_pkg::reg_list'(1) << dec_ldst.rd;
		end

		unique case (cycle)
			core_pkg::ISSUE: begin
				wb_rd <= data_q.rd;
				wb_value <= q_alu;
			end
			core_pkg::TRANSFER: begin
				wb_rd <= final_rd;
				wb_value <= mem_rdata;
			end
			default: begin
				wb_rd <= ldst_q.rn;
				wb_value <= saved_base;
			end
		endcase

		if (cycle == core_pkg::TRANSFER && !started)
			saved_base <= rd_value_a;

		if (launch) begin
			mem.addr <= ldst_q.pre ? q_alu[31:2] : alu_a[31:2];
			mem.write <= !ldst_q.load;
			mem.wdata <= rd_value_b;
			saved_base <= q_alu;
			mem_regs <= ldst_q.increment ? next_lower : next_upper;
			final_rd <= popped;
		end
	end

endmodule

`default_nettype wire

//--- src/core_regs.sv
`default_nettype none
`timescale 1ns/1ps

module core_regs (
	input  logic             clk,
	input  logic             rst_n,
	input  core_pkg::reg_num ra,
	input  core_pkg::reg_num rb,
	output core_pkg::word    rd_value_a,
	output core_pkg::word    rd_value_b,
	input  logic             wb_en,
	input  core_pkg::reg_num wb_rd,
	input  core_pkg::word    wb_value
);

	core_pkg::word regs [core_pkg::NUM_REGS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < core_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wb_en) begin
			regs[wb_rd] <= wb_value;
		end
	end

	// Write in flight is forwarded
	assign rd_value_a = (wb_en && wb_rd == ra) ? wb_value : regs[ra];
	assign rd_value_b = (wb_en && wb_rd == rb) ? wb_value : regs[rb];

endmodule

`default_nettype wire

//--- src/core_alu.sv
`default_nettype none
`timescale 1ns/1ps

module core_alu (
	input  core_pkg::alu_op alu,
	input  core_pkg::word   alu_a,
	input  core_pkg::word   alu_b,
	output core_pkg::word   q_alu
);

	always_comb begin
		unique case (alu)
			core_pkg::OP_ADD: q_alu = alu_a + alu_b;
			core_pkg::OP_SUB: q_alu = alu_a - alu_b;
			core_pkg::OP_AND: q_alu = alu_a & alu_b;
			core_pkg::OP_ORR: q_alu = alu_a | alu_b;
			core_pkg::OP_MOV: q_alu = alu_b;  // Immediate or rm
			default:          q_alu = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- src/core_mem_port.sv
`default_nettype none
`timescale 1ns/1ps

module core_mem_port (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        mem_start,
	input  core_pkg::mem_request        mem,
	output logic                        mem_req,
	output logic [core_pkg::ADDR_W-1:0] mem_addr,
	output logic                        mem_write,
	output core_pkg::word               mem_wdata,
	input  logic                        mem_ack,
	input  core_pkg::word               mem_rdata_in,
	output logic                        mem_done,
	output core_pkg::word               mem_rdata
);

	typedef enum logic [1:0] {
		IDLE,
		REQ,
		RELEASE
	} port_state;

	port_state state;
	core_pkg::mem_request req_q;

	// Fields held for the whole transaction
	assign mem_addr = req_q.addr;
	assign mem_write = req_q.write;
	assign mem_wdata = req_q.wdata;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			mem_req <= 1'b0;
			mem_done <= 1'b0;
		end else begin
			mem_done <= 1'b0;
			unique case (state)
				IDLE: if (mem_start) begin
					mem_req <= 1'b1;
					state <= REQ;
				end
				REQ: if (mem_ack) begin
					mem_req <= 1'b0;
					state <= RELEASE;
				end
				RELEASE: if (!mem_ack) begin
					mem_done <= 1'b1;  // Slave has let go
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && mem_start)
			req_q <= mem;
		if (state == REQ && mem_ack)
			mem_rdata <= mem_rdata_in;
	end

endmodule

`default_nettype wire

//--- src/core.sv
`default_nettype none
`timescale 1ns/1ps

module core (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        insn_req,
	input  core_pkg::word               insn,
	output logic                        insn_ack,
	output logic                        mem_req,
	output logic [core_pkg::ADDR_W-1:0] mem_addr,
	output logic                        mem_write,
	output core_pkg::word               mem_wdata,
	input  logic                        mem_ack,
	input  core_pkg::word               mem_rdata,
	output logic                        wb_en,
	output core_pkg::reg_num            wb_rd,
	output core_pkg::word               wb_value
);

	core_pkg::data_decode dec_data;
	core_pkg::ldst_decode dec_ldst;
	core_pkg::mem_request mem;
	core_pkg::reg_num ra;
	core_pkg::reg_num rb;
	core_pkg::word rd_value_a;
	core_pkg::word rd_value_b;
	core_pkg::word alu_a;
	core_pkg::word alu_b;
	core_pkg::word q_alu;
	core_pkg::word xfer_rdata;  // Load data as captured by the port
	core_pkg::alu_op alu;
	logic ready;
	logic issue;
	logic mem_start;
	logic mem_done;

	core_decode decode (
		.clk(clk),
		.rst_n(rst_n),
		.insn_req(insn_req),
		.insn(insn),
		.ready(ready),
		.insn_ack(insn_ack),
		.issue(issue),
		.dec_data(dec_data),
		.dec_ldst(dec_ldst)
	);

	core_control control (
		.clk(clk),
		.rst_n(rst_n),
		.issue(issue),
		.dec_data(dec_data),
		.dec_ldst(dec_ldst),
		.rd_value_a(rd_value_a),
		.rd_value_b(rd_value_b),
		.q_alu(q_alu),
		.mem_done(mem_done),
		.mem_rdata(xfer_rdata),
		.ready(ready),
		.ra(ra),
		.rb(rb),
		.alu(alu),
		.alu_a(alu_a),
		.alu_b(alu_b),
		.mem_start(mem_start),
		.mem(mem),
		.wb_en(wb_en),
		.wb_rd(wb_rd),
		.wb_value(wb_value)
	);

	core_regs regs (
		.clk(clk),
		.rst_n(rst_n),
		.ra(ra),
		.rb(rb),
		.rd_value_a(rd_value_a),
		.rd_value_b(rd_value_b),
		.wb_en(wb_en),
		.wb_rd(wb_rd),
		.wb_value(wb_value)
	);

	core_alu alu_unit (
		.alu(alu),
		.alu_a(alu_a),
		.alu_b(alu_b),
		.q_alu(q_alu)
	);

	core_mem_port mem_port (
		.clk(clk),
		.rst_n(rst_n),
		.mem_start(mem_start),
		.mem(mem),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_write(mem_write),
		.mem_wdata(mem_wdata),
		.mem_ack(mem_ack),
		.mem_rdata_in(mem_rdata),
		.mem_done(mem_done),
		.mem_rdata(xfer_rdata)
	);

endmodule

`default_nettype wire

//--- testbench/core_assert.sv
`default_nettype none
`timescale 1ns/1ps

module core_assert (
	input wire logic                clk,
	input wire logic                rst_n,
	input wire logic                insn_req,
	input wire core_pkg::word       insn,
	input wire logic                insn_ack,
	input wire logic                mem_req,
	input wire logic [29:0]         mem_addr,
	input wire logic                mem_write,
	input wire core_pkg::word       mem_wdata,
	input wire logic                mem_ack,
	input wire logic                wb_en,
	input wire core_pkg::reg_num    wb_rd,
	input wire core_pkg::word       wb_value,
	input wire core_pkg::ctrl_cycle cycle
);

	a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !insn_ack && !mem_req && !wb_en)
		else $error("outputs not low after reset");

	// Instruction port, four-phase
	a_insn_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(insn_ack) |-> insn_req) else $error("insn_ack rose without insn_req");
	a_insn_req_fall: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(insn_req) |-> insn_ack) else $error("insn_req dropped before insn_ack");
	a_insn_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(insn_ack) |-> !insn_req) else $error("insn_ack dropped while insn_req high");
	a_insn_stable: assert property (@(posedge clk) disable iff (!rst_n)
		insn_req && $past(insn_req) |-> $stable(insn)) else $error("insn changed under req");

	// Memory port, four-phase
	a_mem_req_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(mem_req) |-> !mem_ack) else $error("mem_req rose before mem_ack fell");
	a_mem_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(mem_ack) |-> mem_req) else $error("mem_ack rose without mem_req");
	a_mem_req_fall: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(mem_req) |-> mem_ack) else $error("mem_req dropped before mem_ack");
	a_mem_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(mem_ack) |-> !mem_req) else $error("mem_ack dropped while mem_req high");
	a_mem_stable: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req && $past(mem_req) |-> $stable({mem_addr, mem_write, mem_wdata}))
		else $error("memory request fields changed under req");

	a_no_ack_busy: assert property (@(posedge clk) disable iff (!rst_n)
		cycle != core_pkg::ISSUE |-> !$rose(insn_ack))
		else $error("insn_ack rose during a memory instruction");
	a_wb_known: assert property (@(posedge clk) disable iff (!rst_n)
		wb_en |-> !$isunknown({wb_rd, wb_value})) else $error("writeback trace unknown");

endmodule

bind core core_assert checks (
	.clk(clk),
	.rst_n(rst_n),
	.insn_req(insn_req),
	.insn(insn),
	.insn_ack(insn_ack),
	.mem_req(mem_req),
	.mem_addr(mem_addr),
	.mem_write(mem_write),
	.mem_wdata(mem_wdata),
	.mem_ack(mem_ack),
	.wb_en(wb_en),
	.wb_rd(wb_rd),
	.wb_value(wb_value),
	.cycle(control.cycle)
);

`default_nettype wire

//--- testbench/core_tb.sv
`default_nettype none
`timescale 1ns/1ps

module core_tb;

	localparam int TIMEOUT = 2000;

	logic clk = 1'b0;
	logic rst_n;
	logic insn_req;
	core_pkg::word insn;
	logic insn_ack;
	logic mem_req;
	logic [29:0] mem_addr;
	logic mem_write;
	core_pkg::word mem_wdata;
	logic mem_ack;
	core_pkg::word mem_rdata;
	logic wb_en;
	core_pkg::reg_num wb_rd;
	core_pkg::word wb_value;

	core_pkg::word mem_arr [256];
	core_pkg::word ref_mem [256];  // Reference image
	core_pkg::word ref_regs [16];
	core_pkg::reg_num exp_wb_rd [$];
	core_pkg::word exp_wb_val [$];
	logic [29:0] exp_maddr [$];
	logic exp_mwrite [$];
	core_pkg::word exp_mwdata [$];

	core UUT (.*);

	always #4 clk = !clk;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input core_pkg::word got,
			input core_pkg::word exp);
		assert (got === exp) else
			fail_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp));
	endtask

	function automatic core_pkg::word alu_result(input int op, input core_pkg::word a,
			input core_pkg::word b);
		case (op)
			0: return a + b;
			1: return a - b;
			2: return a & b;
			3: return a | b;
			default: return b;  // Move
		endcase
	endfunction

	task automatic send_insn(input core_pkg::word w);
		int n;
		n = 0;
		@(posedge clk);
		insn <= w;
		insn_req <= 1'b1;
		while (insn_ack !== 1'b1) begin
			@(posedge clk);
			n++;
			if (n > TIMEOUT)
				fail_run("timeout waiting for insn_ack to rise");
		end
		insn_req <= 1'b0;
		n = 0;
		while (insn_ack !== 1'b0) begin
			@(posedge clk);
			n++;
			if (n > TIMEOUT)
				fail_run("timeout waiting for insn_ack to fall");
		end
	endtask

	task automatic expect_wb(input core_pkg::reg_num r, input core_pkg::word v);
		exp_wb_rd.push_back(r);
		exp_wb_val.push_back(v);
		ref_regs[r] = v;
	endtask

	// One word transfer in the reference model
	task automatic model_xfer(input bit load, input core_pkg::word addr,
			input core_pkg::reg_num r);
		exp_maddr.push_back(addr[31:2]);
		exp_mwrite.push_back(!load);
		exp_mwdata.push_back(ref_regs[r]);
		if (load)
			expect_wb(r, ref_mem[addr[9:2]]);
		else
			ref_mem[addr[9:2]] = ref_regs[r];
	endtask

	task automatic do_data(input int op, input bit imm, input core_pkg::reg_num rd,
			input core_pkg::reg_num rn, input core_pkg::reg_num rm, input logic [11:0] k);
		core_pkg::word b;
		b = imm ? {20'b0, k} : ref_regs[rm];
		expect_wb(rd, alu_result(op, ref_regs[rn], b));
		send_insn({2'b00, op[2:0], imm, 2'b00, rd, rn, 4'b0, imm ? k : {8'b0, rm}});
	endtask

	task automatic do_single(input bit load, input bit pre, input bit inc, input bit wb,
			input core_pkg::reg_num rd, input core_pkg::reg_num rn, input logic [11:0] off);
		core_pkg::word base;
		core_pkg::word upd;
		base = ref_regs[rn];
		upd = inc ? base + off : base - off;
		model_xfer(load, pre ? upd : base, rd);
		if (wb)
			expect_wb(rn, upd);
		send_insn({2'b01, load, pre, inc, 1'b0, wb, 1'b0, rd, rn, 4'b0, off});
	endtask

	task automatic do_multi(input bit load, input bit pre, input bit inc, input bit wb,
			input core_pkg::reg_num rn, input core_pkg::reg_list list);
		core_pkg::word b;
		core_pkg::word upd;
		int r;
		b = ref_regs[rn];
		for (int i = 0; i < 16; i++) begin
			r = inc ? i : 15 - i;  // Lowest first going up
			if (list[r]) begin
				upd = inc ? b + 4 : b - 4;
				model_xfer(load, pre ? upd : b, core_pkg::reg_num'(r));
				b = upd;
			end
		end
		if (wb)
			expect_wb(rn, b);
		send_insn({2'b10, load, pre, inc, 1'b0, wb, 1'b0, 4'b0, rn, list});
	endtask

	// Writeback trace against the reference
	always @(posedge clk) begin
		if (rst_n === 1'b1 && wb_en === 1'b1) begin
			if (exp_wb_rd.size() == 0) begin
				fail_run("writeback seen with no instruction expecting one");
			end else begin
				check_value("wb_rd", core_pkg::word'(wb_rd), core_pkg::word'(exp_wb_rd.pop_front()));
				check_value("wb_value", wb_value, exp_wb_val.pop_front());
			end
		end
	end

	task automatic serve_mem();
		int n;
		if (exp_maddr.size() == 0)
			fail_run("memory request with no transfer expected");
		check_value("mem_addr", core_pkg::word'(mem_addr), core_pkg::word'(exp_maddr.pop_front()));
		check_value("mem_write", core_pkg::word'(mem_write),
			core_pkg::word'(exp_mwrite.pop_front()));
		if (mem_write)
			check_value("mem_wdata", mem_wdata, exp_mwdata.pop_front());
		else
			void'(exp_mwdata.pop_front());
		repeat ($urandom_range(0, 4)) @(posedge clk);
		if (mem_write)
			mem_arr[mem_addr[7:0]] = mem_wdata;
		mem_rdata <= mem_arr[mem_addr[7:0]];
		mem_ack <= 1'b1;
		n = 0;
		while (mem_req !== 1'b0) begin
			@(posedge clk);
			n++;
			if (n > TIMEOUT)
				fail_run("timeout waiting for mem_req to fall");
		end
		repeat ($urandom_range(0, 3)) @(posedge clk);
		mem_ack <= 1'b0;
		@(posedge clk);
	endtask

	initial begin
		forever begin
			@(posedge clk);
			if (rst_n === 1'b1 && mem_req === 1'b1 && mem_ack === 1'b0)
				serve_mem();
		end
	end

	initial begin
		int n;
		void'($urandom(32'h9ec8_084c));
		rst_n = 1'b0;
		insn_req = 1'b0;
		insn = '0;
		mem_ack = 1'b0;
		mem_rdata = '0;
		for (int i = 0; i < 256; i++) begin
			mem_arr[i] = 32'h9e37_79b9 ^ (i * 32'h0001_0103);
			ref_mem[i] = mem_arr[i];
		end
		for (int i = 0; i < 16; i++)
			ref_regs[i] = '0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		check_value("insn_ack", core_pkg::word'(insn_ack), 0);
		check_value("mem_req", core_pkg::word'(mem_req), 0);
		check_value("wb_en", core_pkg::word'(wb_en), 0);

		do_data(4, 1, 1, 0, 0, 12'h100);   // MOV r1, base
		do_data(4, 1, 2, 0, 0, 12'h055);
		do_data(0, 1, 3, 1, 0, 12'h004);
		do_data(1, 0, 4, 3, 2, 12'h000);
		do_data(2, 1, 5, 4, 0, 12'h0ff);
		do_data(3, 0, 6, 5, 2, 12'h000);
		do_data(4, 0, 7, 0, 6, 12'h000);   // MOV from rm
		do_single(0, 1, 1, 0, 2, 1, 12'h008);
		do_single(1, 1, 1, 0, 8, 1, 12'h008);
		do_single(1, 0, 1, 1, 9, 1, 12'h008);  // Post-index with writeback
		do_single(0, 1, 0, 1, 3, 1, 12'h004);
		do_multi(0, 0, 1, 1, 1, 16'h00fc | core_pkg::reg_list'($urandom()));
		do_multi(1, 1, 0, 1, 1, 16'h00fc | core_pkg::reg_list'($urandom()));
		do_multi(0, 1, 0, 1, 1, 16'h0a5c | core_pkg::reg_list'($urandom()));
		do_multi(1, 0, 1, 1, 1, 16'h0a5c | core_pkg::reg_list'($urandom()));

		for (int t = 0; t < 40; t++) begin
			case ($urandom_range(0, 2))
				0: do_data($urandom_range(0, 4), 1'($urandom()), 4'($urandom()),
					4'($urandom()), 4'($urandom()), 12'($urandom()));
				1: do_single(1'($urandom()), 1'($urandom()), 1'($urandom()), 1'($urandom()),
					4'($urandom()), 4'($urandom()), 12'($urandom()) & 12'hffc);
				default: do_multi(1'($urandom()), 1'($urandom()), 1'($urandom()),
					1'($urandom()), 4'($urandom()),
					core_pkg::reg_list'($urandom()) | (16'h1 << $urandom_range(0, 15)));
			endcase
		end

		n = 0;
		while (exp_wb_rd.size() != 0 || exp_maddr.size() != 0) begin
			@(posedge clk);
			n++;
			if (n > TIMEOUT)
				fail_run("timeout waiting for outstanding writebacks and transfers");
		end
		repeat (4) @(posedge clk);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- core.f
src/core_pkg.sv
src/core_ldst_pop.sv
src/core_decode.sv
src/core_control.sv
src/core_regs.sv
src/core_alu.sv
src/core_mem_port.sv
src/core.sv
testbench/core_assert.sv
testbench/core_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --assert --timing
TOP       = core_tb
FILELIST  = core.f
OBJ_DIR   = obj_dir

BIN  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
